// ==== dekatronPkg.sv ====
package dekatronPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // digit format
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int DekatronWidth = 4;   // one BCD digit per dekatron tube

    typedef logic [DekatronWidth-1:0] digit_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host commands
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        MoveRight = 2'd0,
        MoveLeft  = 2'd1,
        Increment = 2'd2,
        Decrement = 2'd3
    } cmdOp_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // counter geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int ApDigits   = 5;
    localparam int DataDigits = 3;

    // top values are written digit by digit, so the hex literal reads as decimal
    localparam logic [ApDigits*DekatronWidth-1:0]   ApTop   = 20'h29999;
    localparam logic [DataDigits*DekatronWidth-1:0] DataTop = 12'h255;

endpackage

// ==== tapeIf.sv ====
`timescale 1ns/1ns

// handshake between the tape line and one decimal counter
interface CounterIf #(
    parameter int Digits = 3
);
    import dekatronPkg::*;

    logic                            Request;
    logic                            Dec;
    logic                            Set;     // load In instead of counting
    logic [Digits*DekatronWidth-1:0] In;
    logic                            Ready;
    logic [Digits*DekatronWidth-1:0] Out;
    logic                            Zero;

    modport controller (output Request, Dec, Set, In, input Ready, Out, Zero);
    modport counter (input Request, Dec, Set, In, output Ready, Out, Zero);
endinterface

interface RamIf #(
    parameter int AddrDigits = 5,
    parameter int DataDigits = 3
);
    import dekatronPkg::*;

    logic [AddrDigits*DekatronWidth-1:0] Address;   // decimal, straight from the pointer
    logic [DataDigits*DekatronWidth-1:0] WrData;
    logic [DataDigits*DekatronWidth-1:0] RdData;
    logic                                WE;

    modport controller (output Address, WrData, WE, input RdData);
    modport ram (input Address, WrData, WE, output RdData);
endinterface

// ==== DekatronCounter.sv ====
`timescale 1ns/1ns

module DekatronCounter #(
    parameter int Digits = 3,
    parameter logic [Digits*dekatronPkg::DekatronWidth-1:0] TopValue = '0
) (
    input  logic      Clk,
    input  logic      Rst_n,
    input  logic      step,
    CounterIf.counter ctl
);
    import dekatronPkg::*;

    localparam int ValueW = Digits*DekatronWidth;

    logic [ValueW-1:0] value;
    logic [ValueW-1:0] nextValue;
    logic [ValueW-1:0] loadValue;
    logic              readyReg;
    logic              decLatched;
    logic              setLatched;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next value, ripple across the digits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin : nextStep
        digit_t d;
        logic   carry;
        nextValue = value;
        carry = 1'b1;
        d = '0;
        if (setLatched) begin
            nextValue = loadValue;
        end else if (!decLatched) begin
            if (value == TopValue) begin
                nextValue = '0;                     // wrap upward to zero
            end else begin
                for (int i = 0; i < Digits; i++) begin
                    d = value[i*DekatronWidth +: DekatronWidth];
                    if (carry) begin
                        if (d == digit_t'(9)) begin
                            d = '0;                 // carry into the next tube
                        end else begin
                            d = d + 1'b1;
                            carry = 1'b0;
                        end
                    end
                    nextValue[i*DekatronWidth +: DekatronWidth] = d;
                end
            end
        end else begin
            if (value == '0) begin
                nextValue = TopValue;               // wrap downward to the top value
            end else begin
                for (int i = 0; i < Digits; i++) begin
                    d = value[i*DekatronWidth +: DekatronWidth];
                    if (carry) begin
                        if (d == '0) begin
                            d = digit_t'(9);        // borrow from the next tube
                        end else begin
                            d = d - 1'b1;
                            carry = 1'b0;
                        end
                    end
                    nextValue[i*DekatronWidth +: DekatronWidth] = d;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the step waits for the slow strobe, so Ready stays low for a variable time
    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            value    <= '0;
            readyReg <= 1'b1;
        end else if (ctl.Request && readyReg) begin
            readyReg <= 1'b0;
        end else if (!readyReg && step) begin
            value    <= nextValue;
            readyReg <= 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (ctl.Request && readyReg) begin
            decLatched <= ctl.Dec;
            setLatched <= ctl.Set;
            loadValue  <= ctl.In;   // the source may change once the request is taken
        end
    end

    assign ctl.Ready = readyReg;
    assign ctl.Out   = value;
    assign ctl.Zero  = (value == '0);

endmodule

// ==== StepPulseGen.sv ====
`timescale 1ns/1ns

module StepPulseGen #(
    parameter int StepDiv = 4
) (
    input  logic Clk,
    input  logic Rst_n,
    output logic step
);

    localparam int CntW = (StepDiv > 1) ? $clog2(StepDiv) : 1;

    logic [CntW-1:0] divCnt;

    // one strobe per StepDiv cycles, like the slow glow transfer of a real tube
    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            divCnt <= '0;
            step   <= 1'b0;
        end else if (divCnt == CntW'(StepDiv - 1)) begin
            divCnt <= '0;
            step   <= 1'b1;
        end else begin
            divCnt <= divCnt + 1'b1;
            step   <= 1'b0;
        end
    end

endmodule

// ==== CellRam.sv ====
`timescale 1ns/1ns

module CellRam #(
    parameter int Digits     = 5,
    parameter int DataDigits = 3,
    parameter logic [Digits*dekatronPkg::DekatronWidth-1:0] TopValue = '0
) (
    input  logic Clk,
    RamIf.ram    mem
);
    import dekatronPkg::*;

    // weight the digits by powers of ten, most significant tube first
    function automatic int bcdToBin(input logic [Digits*DekatronWidth-1:0] bcd);
        int acc;
        acc = 0;
        for (int i = Digits - 1; i >= 0; i--) begin
            acc = acc * 10 + int'(bcd[i*DekatronWidth +: DekatronWidth]);
        end
        return acc;
    endfunction

    localparam int Depth  = bcdToBin(TopValue) + 1;
    localparam int IndexW = $clog2(Depth);

    logic [DataDigits*DekatronWidth-1:0] cells [Depth];
    logic [IndexW-1:0]                   index;

    initial begin
        for (int i = 0; i < Depth; i++) begin
            cells[i] = '0;      // a fresh tape is all zero cells
        end
    end

    assign index      = IndexW'(bcdToBin(mem.Address));
    assign mem.RdData = cells[index];

    always_ff @(posedge Clk) begin
        if (mem.WE) begin
            cells[index] <= mem.WrData;
        end
    end

endmodule

// ==== CommandFifo.sv ====
`timescale 1ns/1ns

module CommandFifo #(
    parameter int Depth = 4
) (
    input  logic                Clk,
    input  logic                Rst_n,
    input  logic                inValid,
    output logic                inReady,
    input  dekatronPkg::cmdOp_t inOp,
    output logic                outValid,
    input  logic                outReady,
    output dekatronPkg::cmdOp_t outOp,
    output logic                empty
);
    import dekatronPkg::*;

    localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW = $clog2(Depth + 1);

    cmdOp_t          buffer [Depth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;
    logic            push;
    logic            pop;

    assign inReady  = (count != CntW'(Depth));
    assign outValid = (count != '0);
    assign empty    = (count == '0);
    assign outOp    = buffer[rdPtr];    // head is visible the cycle after the write
    assign push     = inValid & inReady;
    assign pop      = outValid & outReady;

    always_ff @(posedge Clk) begin
        if (push) begin
            buffer[wrPtr] <= inOp;
        end
    end

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== ApLine.sv ====
`timescale 1ns/1ns

module ApLine #(
    parameter int DataDigits = dekatronPkg::DataDigits
) (
    input  logic                Clk,
    input  logic                Rst_n,
    input  logic                cmdValid,
    output logic                cmdReady,
    input  dekatronPkg::cmdOp_t cmdOp,
    CounterIf.controller        ap,
    CounterIf.controller        data,
    RamIf.controller            mem,
    output logic [DataDigits*dekatronPkg::DekatronWidth-1:0] Data
);
    import dekatronPkg::*;

    typedef enum logic [3:0] {
        Idle  = 4'b0001,
        Load  = 4'b0010,
        Store = 4'b0100,
        Count = 4'b1000
    } lineState_t;

    lineState_t currentState;
    cmdOp_t     curOp;          // held for Dec after the FIFO head has moved on
    logic       apRequest;
    logic       dataRequest;
    logic       dataSet;
    logic       ramWe;
    logic       memLock;        // the data counter holds the live cell
    logic       accept;
    logic       isMove;

    assign cmdReady = (currentState == Idle) & ap.Ready & data.Ready;
    assign accept   = cmdValid & cmdReady;
    assign isMove   = (cmdOp == MoveRight) || (cmdOp == MoveLeft);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // counter and RAM wiring
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign ap.Request   = apRequest;
    assign ap.Dec       = (curOp == MoveLeft);
    assign ap.Set       = 1'b0;         // the pointer only ever counts
    assign ap.In        = '0;
    assign data.Request = dataRequest;
    assign data.Dec     = (curOp == Decrement);
    assign data.Set     = dataSet;
    assign data.In      = mem.RdData;

    assign mem.Address = ap.Out;
    assign mem.WrData  = data.Out;
    assign mem.WE      = ramWe;

    assign Data = memLock ? data.Out : mem.RdData;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tape line FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            currentState <= Idle;
            curOp        <= MoveRight;
            apRequest    <= 1'b0;
            dataRequest  <= 1'b0;
            dataSet      <= 1'b0;
            ramWe        <= 1'b0;
            memLock      <= 1'b0;
        end else begin
            case (currentState)
                Idle: begin
                    if (accept) begin
                        curOp <= cmdOp;
                        if (isMove && memLock) begin
                            ramWe        <= 1'b1;   // flush the cached cell before moving
                            currentState <= Store;
                        end else if (isMove) begin
                            apRequest    <= 1'b1;
                            currentState <= Count;
                        end else if (!memLock) begin
                            dataSet      <= 1'b1;
                            dataRequest  <= 1'b1;
                            currentState <= Load;
                        end else begin
                            dataRequest  <= 1'b1;
                            currentState <= Count;
                        end
                    end
                end
                Load: begin
                    memLock     <= 1'b1;
                    dataRequest <= 1'b0;
                    dataSet     <= 1'b0;
                    // the count request goes out once the load has landed
                    if (!dataRequest && data.Ready) begin
                        dataRequest  <= 1'b1;
                        currentState <= Count;
                    end
                end
                Store: begin
                    ramWe        <= 1'b0;
                    memLock      <= 1'b0;
                    apRequest    <= 1'b1;
                    currentState <= Count;
                end
                Count: begin
                    apRequest   <= 1'b0;
                    dataRequest <= 1'b0;
                    if (!apRequest && !dataRequest && ap.Ready && data.Ready) begin
                        currentState <= Idle;
                    end
                end
                default: currentState <= Idle;
            endcase
        end
    end

endmodule

// ==== TapeMachine.sv ====
`timescale 1ns/1ns

module TapeMachine #(
    parameter int FifoDepth = 4,
    parameter int StepDiv   = 4
) (
    input  logic                Clk,
    input  logic                Rst_n,
    input  logic                cmdValid,
    output logic                cmdReady,
    input  dekatronPkg::cmdOp_t cmdOp,
    output logic [dekatronPkg::ApDigits*dekatronPkg::DekatronWidth-1:0]   Address,
    output logic [dekatronPkg::DataDigits*dekatronPkg::DekatronWidth-1:0] Data,
    output logic                ApZero,
    output logic                DataZero,
    output logic                Idle
);
    import dekatronPkg::*;

    logic   step;
    logic   fifoValid;
    logic   fifoEmpty;
    logic   lineReady;
    cmdOp_t fifoOp;

    CounterIf #(.Digits(ApDigits))   apBus ();
    CounterIf #(.Digits(DataDigits)) dataBus ();
    RamIf #(.AddrDigits(ApDigits), .DataDigits(DataDigits)) ramBus ();

    CommandFifo #(.Depth(FifoDepth)) commandFifo (
        .Clk(Clk), .Rst_n(Rst_n),
        .inValid(cmdValid), .inReady(cmdReady), .inOp(cmdOp),
        .outValid(fifoValid), .outReady(lineReady), .outOp(fifoOp),
        .empty(fifoEmpty)
    );

    ApLine #(.DataDigits(DataDigits)) apLine (
        .Clk(Clk), .Rst_n(Rst_n),
        .cmdValid(fifoValid), .cmdReady(lineReady), .cmdOp(fifoOp),
        .ap(apBus.controller), .data(dataBus.controller), .mem(ramBus.controller),
        .Data(Data)
    );

    DekatronCounter #(.Digits(ApDigits), .TopValue(ApTop)) apCounter (
        .Clk(Clk), .Rst_n(Rst_n), .step(step), .ctl(apBus.counter)
    );

    DekatronCounter #(.Digits(DataDigits), .TopValue(DataTop)) dataCounter (
        .Clk(Clk), .Rst_n(Rst_n), .step(step), .ctl(dataBus.counter)
    );

    StepPulseGen #(.StepDiv(StepDiv)) stepGen (
        .Clk(Clk), .Rst_n(Rst_n), .step(step)
    );

    CellRam #(.Digits(ApDigits), .DataDigits(DataDigits), .TopValue(ApTop)) cellRam (
        .Clk(Clk), .mem(ramBus.ram)
    );

    assign Address = apBus.Out;
    assign ApZero  = apBus.Zero;
    assign Idle    = fifoEmpty & lineReady;

    // after a move the data counter keeps the old cell until the next load,
    // so the flag follows the shown value rather than the counter
    assign DataZero = (Data == '0);

endmodule

// ==== tbClock.sv ====
`timescale 1ns/1ns

module tbClock #(
    parameter int Period      = 10,
    parameter int ResetCycles = 10
) (
    output logic Clk,
    output logic Rst_n
);

    initial begin
        Clk = 1'b0;
        forever #(Period/2) Clk = ~Clk;
    end

    initial begin
        Rst_n = 1'b0;
        repeat (ResetCycles) @(posedge Clk);
        Rst_n <= 1'b1;      // released on a rising edge like the other inputs
    end

endmodule

// ==== TapeMachine_properties.sv ====
`timescale 1ns/1ns

module TapeMachine_properties (
    input logic Clk,
    input logic Rst_n,
    input logic ramWe,
    input logic lineReady,
    input logic cmdValid,
    input logic apRequest,
    input logic apReady,
    input logic dataRequest,
    input logic dataReady
);

    // a store is a single write strobe
    weSingleCycle: assert property (@(posedge Clk) disable iff (!Rst_n) ramWe |=> !ramWe)
        else $error("RAM write enable stayed high for more than one cycle");

    // a taken command moves the FSM out of idle, so ready drops at once
    readyDropsOnAccept: assert property (@(posedge Clk) disable iff (!Rst_n)
        (lineReady && cmdValid) |=> !lineReady)
        else $error("tape line stayed ready after taking a command");

    // requests are only taken while the counter is ready
    apRequestWhileBusy: assert property (@(posedge Clk) disable iff (!Rst_n)
        apRequest |-> apReady)
        else $error("pointer counter request while the counter was busy");

    dataRequestWhileBusy: assert property (@(posedge Clk) disable iff (!Rst_n)
        dataRequest |-> dataReady)
        else $error("data counter request while the counter was busy");

endmodule

bind ApLine TapeMachine_properties lineProps (
    .Clk(Clk), .Rst_n(Rst_n), .ramWe(ramWe), .lineReady(cmdReady),
    .cmdValid(cmdValid), .apRequest(apRequest), .apReady(ap.Ready),
    .dataRequest(dataRequest), .dataReady(data.Ready)
);

// ==== TapeMachine_tb.sv ====
`timescale 1ns/1ns

module TapeMachine_tb;
    import dekatronPkg::*;

    localparam int FifoDepth      = 4;
    localparam int StepDiv        = 4;
    localparam int ClkPeriod      = 10;
    localparam int AddrW          = ApDigits*DekatronWidth;
    localparam int DataW          = DataDigits*DekatronWidth;
    localparam int ApMax          = 29999;
    localparam int CellMax        = 255;
    localparam int IncCount       = 300;
    localparam int MixCount       = 60;
    localparam int SetCellMax     = (CellMax + 1) / 2;  // setCell goes the short way round
    localparam int TotalCommands  = 1 + IncCount + 2 + 2*SetCellMax + 3 + FifoDepth + 5
                                    + MixCount;
    localparam int WorstLatency   = 4*StepDiv + 12; // store, load and count each wait a strobe
    localparam int WatchdogCycles = TotalCommands*WorstLatency + 100;

    logic             Clk;
    logic             Rst_n;
    logic             cmdValid;
    logic             cmdReady;
    cmdOp_t           cmdOp;
    logic [AddrW-1:0] Address;
    logic [DataW-1:0] Data;
    logic             ApZero;
    logic             DataZero;
    logic             Idle;

    integer seed = 32'hdfc2_79d1;
    int     ptrModel;
    int     cells [int];
    int     errorCount;
    int     testErrors;
    int     testsRun;
    int     testsFailed;
    bit     sawStall;

    tbClock #(.Period(ClkPeriod), .ResetCycles(10)) clockGen (.Clk(Clk), .Rst_n(Rst_n));

    TapeMachine #(.FifoDepth(FifoDepth), .StepDiv(StepDiv)) TapeMachine_i (
        .Clk(Clk), .Rst_n(Rst_n), .cmdValid(cmdValid), .cmdReady(cmdReady), .cmdOp(cmdOp),
        .Address(Address), .Data(Data), .ApZero(ApZero), .DataZero(DataZero), .Idle(Idle)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic int cellAt(input int addr);
        return cells.exists(addr) ? cells[addr] : 0;
    endfunction

    function automatic logic [AddrW-1:0] toBcd(input int value);
        logic [AddrW-1:0] bcd;
        int               rest;
        bcd  = '0;
        rest = value;
        for (int i = 0; i < ApDigits; i++) begin
            bcd[i*DekatronWidth +: DekatronWidth] = DekatronWidth'(rest % 10);
            rest = rest / 10;
        end
        return bcd;
    endfunction

    function automatic void applyModel(input cmdOp_t op);
        int v;
        v = cellAt(ptrModel);
        case (op)
            MoveRight: ptrModel = (ptrModel == ApMax) ? 0 : ptrModel + 1;
            MoveLeft:  ptrModel = (ptrModel == 0) ? ApMax : ptrModel - 1;
            Increment: cells[ptrModel] = (v == CellMax) ? 0 : v + 1;
            default:   cells[ptrModel] = (v == 0) ? CellMax : v - 1;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // driving and checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic reportError(input string name, input string msg);
        $display("[ERROR] %0t ns %s: %s", $time, name, msg);
        errorCount++;
        testErrors++;
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (testErrors != 0) begin
            testsFailed++;
        end
        $display("test %s done, %0d errors", name, testErrors);
    endtask

    // called on a rising edge, returns on the edge where the command transfers
    task automatic pushCommand(input cmdOp_t op);
        cmdValid <= 1'b1;
        cmdOp    <= op;
        @(negedge Clk);
        while (!cmdReady) begin
            sawStall = 1'b1;
            @(negedge Clk);
        end
        @(posedge Clk);
        applyModel(op);
    endtask

    task automatic waitIdle();
        @(negedge Clk);
        while (!Idle) @(negedge Clk);
    endtask

    task automatic checkState(input string name);
        logic [AddrW-1:0] expAddr;
        logic [DataW-1:0] expData;
        expAddr = toBcd(ptrModel);
        expData = DataW'(toBcd(cellAt(ptrModel)));
        if (Address !== expAddr) begin
            reportError(name, $sformatf("Address %h, expected %h", Address, expAddr));
        end
        if (Data !== expData) begin
            reportError(name, $sformatf("Data %h, expected %h", Data, expData));
        end
        if (ApZero !== (ptrModel == 0)) begin
            reportError(name, $sformatf("ApZero %b, expected %b", ApZero, ptrModel == 0));
        end
        if (DataZero !== (cellAt(ptrModel) == 0)) begin
            reportError(name, $sformatf("DataZero %b, expected %b", DataZero,
                                        cellAt(ptrModel) == 0));
        end
    endtask

    task automatic runCommand(input cmdOp_t op, input string name);
        @(posedge Clk);
        pushCommand(op);
        cmdValid <= 1'b0;
        waitIdle();
        checkState(name);
    endtask

    task automatic setCell(input int target, input string name);
        int delta;
        delta = (target - cellAt(ptrModel) + CellMax + 1) % (CellMax + 1);
        if (delta <= (CellMax + 1) / 2) begin
            repeat (delta) runCommand(Increment, name);
        end else begin
            repeat (CellMax + 1 - delta) runCommand(Decrement, name);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic resetTest();
        testErrors = 0;
        wait (Rst_n === 1'b1);
        @(negedge Clk);
        if (Idle !== 1'b1) begin
            reportError("reset", "Idle is not high after reset");
        end
        checkState("reset");
        finishTest("reset");
    endtask

    task automatic cellWrapTest();
        testErrors = 0;
        runCommand(Decrement, "cell wrap");
        if (Data !== 12'h255) begin
            reportError("cell wrap", $sformatf("Data %h after decrement from 0", Data));
        end
        for (int i = 0; i < IncCount; i++) begin
            runCommand(Increment, "cell wrap");
        end
        finishTest("cell wrap");
    endtask

    task automatic pointerWrapTest();
        testErrors = 0;
        runCommand(MoveLeft, "pointer wrap");
        if (Address !== 20'h29999) begin
            reportError("pointer wrap", $sformatf("Address %h after left from 0", Address));
        end
        runCommand(MoveRight, "pointer wrap");
        if (Address !== '0 || ApZero !== 1'b1) begin
            reportError("pointer wrap", "pointer did not return to 0 with ApZero high");
        end
        finishTest("pointer wrap");
    endtask

    task automatic writeBackTest();
        testErrors = 0;
        setCell(7, "write-back");
        runCommand(MoveRight, "write-back");
        setCell(3, "write-back");
        runCommand(MoveLeft, "write-back");
        if (Data !== 12'h007) begin
            reportError("write-back", $sformatf("Data %h back on cell 0, expected 007", Data));
        end
        runCommand(MoveRight, "write-back");
        if (Data !== 12'h003) begin
            reportError("write-back", $sformatf("Data %h back on cell 1, expected 003", Data));
        end
        finishTest("write-back");
    endtask

    task automatic backPressureTest();
        int          burst;
        logic [31:0] rnd;
        testErrors = 0;
        sawStall   = 1'b0;
        rnd        = $random(seed);
        burst      = FifoDepth + 2 + int'(rnd[1:0]);
        @(posedge Clk);
        for (int i = 0; i < burst; i++) begin
            rnd = $random(seed);
            // only data commands, so a lost or doubled one shifts the final cell
            pushCommand(cmdOp_t'({1'b1, rnd[0]}));    // valid stays high through the burst
        end
        cmdValid <= 1'b0;
        waitIdle();
        checkState("back-pressure");
        @(posedge Clk);
        if (!sawStall) begin
            reportError("back-pressure", "cmdReady never fell during the burst");
        end
        finishTest("back-pressure");
    endtask

    task automatic randomMixTest();
        logic [31:0] rnd;
        testErrors = 0;
        for (int i = 0; i < MixCount; i++) begin
            rnd = $random(seed);
            runCommand(cmdOp_t'(rnd[1:0]), "random mix");
        end
        finishTest("random mix");
    endtask

    initial begin
        cmdValid    = 1'b0;
        cmdOp       = MoveRight;
        ptrModel    = 0;
        errorCount  = 0;
        testsRun    = 0;
        testsFailed = 0;
        resetTest();
        cellWrapTest();
        pointerWrapTest();
        writeBackTest();
        backPressureTest();
        randomMixTest();
        $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed,
                 errorCount);
        if (errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("watchdog expired after %0d cycles, the DUT never went idle", WatchdogCycles);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== flist.f ====
dekatronPkg.sv
tapeIf.sv
DekatronCounter.sv
StepPulseGen.sv
CellRam.sv
CommandFifo.sv
ApLine.sv
TapeMachine.sv
tbClock.sv
TapeMachine_properties.sv
TapeMachine_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module TapeMachine_tb -o simv \
    && ./obj_dir/simv 2>&1 | tee sim.log \
    || { echo "build or simulation aborted"; exit 1; }

grep -q '\*\* FAIL \*\*' sim.log && { echo "simulation reported failure"; exit 1; }
grep -q '\*\* PASS \*\*' sim.log || { echo "no result found in sim.log"; exit 1; }
exit 0
